/* sim.f */
or1420CiPkg.sv
resetSequencer.sv
dataFormatIse.sv
profileControl.sv
profileCounter.sv
profileReadout.sv
or1420CustomInstructions.sv
tbOr1420CustomInstructions.sv

/* Makefile */
VERILATOR    = verilator
SIM_FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS   = --lint-only --timing --timescale 1ns/1ps -Wall
TOP          = tbOr1420CustomInstructions
FILELIST     = sim.f
OBJDIR       = obj_dir
BINARY       = $(OBJDIR)/V$(TOP)
PASS_MESSAGE = PASS: all tests

SOURCES = $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the run fails unless the pass message appears in the output.
run: $(BINARY)
	@out="$$($(BINARY))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MESSAGE)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* tbOr1420CustomInstructions.sv */
`timescale 1ns/1ps

module tbOr1420CustomInstructions;

  localparam int CLOCK_PERIOD = 4;
  localparam int LOCK_DELAY_CYCLES = 5;

  // one table entry is an instruction followed by a number of cycles without start.
  typedef struct packed {
    or1420CiPkg::ciNumberT number;
    or1420CiPkg::ciWordT   dataA;
    or1420CiPkg::ciWordT   dataB;
    int                    idleCycles;
  } stepT;

  logic                  s_systemClock;
  logic                  s_pllLocked;
  logic                  ciStart;
  logic                  stall;
  logic                  busIdle;
  or1420CiPkg::ciNumberT ciN;
  or1420CiPkg::ciWordT   ciDataA;
  or1420CiPkg::ciWordT   ciDataB;
  logic                  systemReset;
  logic                  ciDone;
  or1420CiPkg::ciWordT   ciResult;

  stepT                      stepTable[$];
  logic                      tableLoaded;
  int                        seed;
  int                        errorCount;
  int                        checkCount;
  or1420CiPkg::profileMaskT  modelRunMask;
  or1420CiPkg::profileCountT modelCount [or1420CiPkg::NR_OF_PROFILE_COUNTERS];

  or1420CustomInstructions uut (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ciStart      (ciStart),
    .stall        (stall),
    .busIdle      (busIdle),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .systemReset  (systemReset),
    .ciDone       (ciDone),
    .ciResult     (ciResult)
  );

  always #(CLOCK_PERIOD / 2) s_systemClock = ~s_systemClock;

  function automatic or1420CiPkg::ciWordT swapBytes(input or1420CiPkg::ciWordT word);
    or1420CiPkg::ciWordT swapped;
    for (int byteIndex = 0; byteIndex < 4; byteIndex++) begin
      swapped[8*byteIndex +: 8] = word[8*(3-byteIndex) +: 8];
    end
    return swapped;
  endfunction

  function automatic or1420CiPkg::ciWordT grayLevel(input or1420CiPkg::ciWordT pixel);
    int red;
    int green;
    int blue;
    int weighted;
    red = int'(pixel[15:11]) * 8;
    green = int'(pixel[10:5]) * 4;
    blue = int'(pixel[4:0]) * 8;
    weighted = red * int'(or1420CiPkg::RED_WEIGHT) + green * int'(or1420CiPkg::GREEN_WEIGHT) +
               blue * int'(or1420CiPkg::BLUE_WEIGHT);
    return or1420CiPkg::ciWordT'(weighted / 256); // the weights sum to 256.
  endfunction

  function automatic or1420CiPkg::ciWordT profileCommand(input or1420CiPkg::profileMaskT startBits,
                                                         input or1420CiPkg::profileMaskT stopBits,
                                                         input or1420CiPkg::profileMaskT clearBits);
    return {20'd0, clearBits, stopBits, startBits};
  endfunction

  function automatic logic ownsNumber(input or1420CiPkg::ciNumberT number);
    return (number == or1420CiPkg::SWAP_BYTE_ID) || (number == or1420CiPkg::GRAYSCALE_ID) ||
           (number == or1420CiPkg::PROFILE_ID);
  endfunction

  function automatic or1420CiPkg::ciWordT expectedResult(input or1420CiPkg::ciNumberT number,
                                                         input or1420CiPkg::ciWordT dataA);
    or1420CiPkg::ciWordT result;
    result = '0;
    case (number)
      or1420CiPkg::SWAP_BYTE_ID: result = swapBytes(dataA);
      or1420CiPkg::GRAYSCALE_ID: result = grayLevel(dataA);
      or1420CiPkg::PROFILE_ID:   result = modelCount[dataA[1:0]]; // value before the edge.
      default:                   result = '0;
    endcase
    return result;
  endfunction

  task automatic checkWord(input or1420CiPkg::ciWordT actual, input or1420CiPkg::ciWordT expected,
                           input string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic checkDone(input logic actual, input logic expected, input string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("** Error at %0t ns: %s, done is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic checkReset(input logic actual, input logic expected, input string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("** Error at %0t ns: %s, reset is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  // applies one clock edge to the model of the run mask and the counters.
  task automatic advanceModel(input logic start, input or1420CiPkg::ciNumberT number,
                              input or1420CiPkg::ciWordT dataB, input logic stallLevel,
                              input logic idleLevel);
    logic                     access;
    or1420CiPkg::profileMaskT events;
    access = start && (number == or1420CiPkg::PROFILE_ID);
    events = {~stallLevel & ~idleLevel, idleLevel, stallLevel, 1'b1};
    for (int index = 0; index < or1420CiPkg::NR_OF_PROFILE_COUNTERS; index++) begin
      if (access && dataB[8+index]) begin
        modelCount[index] = '0;
      end else if (modelRunMask[index] && events[index]) begin
        modelCount[index] = modelCount[index] + 1;
      end
      if (access && dataB[index]) modelRunMask[index] = 1'b1;
      if (access && dataB[4+index]) modelRunMask[index] = 1'b0; // stop after start.
    end
  endtask

  // entered 1 ns after a rising edge, left 1 ns after the next one.
  task automatic runCycle(input logic start, input or1420CiPkg::ciNumberT number,
                          input or1420CiPkg::ciWordT dataA, input or1420CiPkg::ciWordT dataB,
                          input logic stallLevel, input logic idleLevel);
    logic                expectDone;
    or1420CiPkg::ciWordT expectWord;
    ciStart = start;
    ciN = number;
    ciDataA = dataA;
    ciDataB = dataB;
    stall = stallLevel;
    busIdle = idleLevel;
    expectDone = start && ownsNumber(number);
    expectWord = expectDone ? expectedResult(number, dataA) : '0;
    #2;
    checkDone(ciDone, expectDone, $sformatf("instruction %0d start %b", number, start));
    checkWord(ciResult, expectWord, $sformatf("instruction %0d start %b", number, start));
    advanceModel(start, number, dataB, stallLevel, idleLevel);
    @(posedge s_systemClock);
    #1;
  endtask

  task automatic addStep(input or1420CiPkg::ciNumberT number, input or1420CiPkg::ciWordT dataA,
                         input or1420CiPkg::ciWordT dataB, input int idleCycles);
    stepTable.push_back({number, dataA, dataB, idleCycles});
  endtask

  task automatic buildTable();
    logic [31:0] randomWord;
    addStep(or1420CiPkg::SWAP_BYTE_ID, 32'h1234_5678, 32'h0000_0000, 1);
    addStep(or1420CiPkg::SWAP_BYTE_ID, 32'hA5C3_0FF0, 32'hFFFF_FFFF, 0);
    addStep(or1420CiPkg::GRAYSCALE_ID, 32'h0000_0000, '0, 0);
    addStep(or1420CiPkg::GRAYSCALE_ID, 32'h0000_FFFF, '0, 1);
    addStep(or1420CiPkg::GRAYSCALE_ID, 32'h0000_F800, '0, 0); // pure red.
    addStep(or1420CiPkg::GRAYSCALE_ID, 32'h0000_07E0, '0, 0);
    addStep(or1420CiPkg::GRAYSCALE_ID, 32'h0000_001F, '0, 0);
    addStep(or1420CiPkg::GRAYSCALE_ID, 32'hDEAD_8410, '0, 2); // upper half is ignored.
    for (int pixelIndex = 0; pixelIndex < 6; pixelIndex++) begin
      randomWord = $random(seed);
      addStep(or1420CiPkg::GRAYSCALE_ID, randomWord, '0, pixelIndex % 2);
    end
    // all counters start at zero after reset.
    addStep(or1420CiPkg::PROFILE_ID, 32'd0, profileCommand(4'h0, 4'h0, 4'h0), 2);
    addStep(or1420CiPkg::PROFILE_ID, 32'd0, profileCommand(4'hF, 4'h0, 4'h0), 10);
    addStep(or1420CiPkg::PROFILE_ID, 32'd1, profileCommand(4'h0, 4'h0, 4'h0), 7);
    addStep(or1420CiPkg::PROFILE_ID, 32'd2, profileCommand(4'h0, 4'h0, 4'h0), 3);
    addStep(or1420CiPkg::PROFILE_ID, 32'd3, profileCommand(4'h0, 4'h0, 4'h0), 5);
    addStep(or1420CiPkg::PROFILE_ID, 32'd1, profileCommand(4'h0, 4'h2, 4'h0), 6);
    addStep(or1420CiPkg::PROFILE_ID, 32'hFFFF_FFF1, profileCommand(4'h0, 4'h0, 4'h0), 4);
    addStep(or1420CiPkg::PROFILE_ID, 32'd0, profileCommand(4'h0, 4'h0, 4'h1), 3);
    addStep(or1420CiPkg::PROFILE_ID, 32'd0, profileCommand(4'h0, 4'h0, 4'h0), 2);
    addStep(or1420CiPkg::PROFILE_ID, 32'd2, profileCommand(4'h4, 4'h4, 4'h0), 5);
    addStep(or1420CiPkg::PROFILE_ID, 32'd2, profileCommand(4'h0, 4'h0, 4'h0), 2);
    addStep(or1420CiPkg::PROFILE_ID, 32'd3, profileCommand(4'h2, 4'h0, 4'hF), 8);
    addStep(or1420CiPkg::PROFILE_ID, 32'd1, profileCommand(4'h0, 4'h0, 4'h0), 0);
    addStep(or1420CiPkg::PROFILE_ID, 32'd2, profileCommand(4'h0, 4'h0, 4'h0), 0);
    addStep(or1420CiPkg::PROFILE_ID, 32'd3, profileCommand(4'h0, 4'h0, 4'h0), 4);
    addStep(or1420CiPkg::PROFILE_ID, 32'd0, profileCommand(4'h0, 4'h0, 4'h0), 1);
    // numbers that no unit owns.
    addStep(8'd0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1);
    addStep(8'd2, 32'h1234_5678, 32'h0000_0F0F, 0);
    addStep(8'd11, 32'h0000_FFFF, 32'h0000_0000, 1);
    addStep(8'hFF, 32'h8765_4321, 32'h0000_0F00, 2);
    // the unowned numbers above must not have started, stopped or cleared any counter.
    addStep(or1420CiPkg::PROFILE_ID, 32'd0, profileCommand(4'h0, 4'h0, 4'h0), 0);
    addStep(or1420CiPkg::PROFILE_ID, 32'd2, profileCommand(4'h0, 4'h0, 4'h0), 0);
  endtask

  initial begin
    stepT step;
    logic [31:0] randomWord;
    tableLoaded = 1'b0;
    seed = 29262;
    errorCount = 0;
    checkCount = 0;
    s_systemClock = 1'b0;
    s_pllLocked = 1'b0;
    ciStart = 1'b0;
    ciN = '0;
    ciDataA = '0;
    ciDataB = '0;
    stall = 1'b0;
    busIdle = 1'b0;
    modelRunMask = '0;
    for (int index = 0; index < or1420CiPkg::NR_OF_PROFILE_COUNTERS; index++) begin
      modelCount[index] = '0;
    end
    buildTable();
    tableLoaded = 1'b1;

    repeat (LOCK_DELAY_CYCLES) begin
      @(posedge s_systemClock);
      #1;
      checkReset(systemReset, 1'b1, "PLL not locked");
      checkDone(ciDone, 1'b0, "idle bus during reset");
    end
    s_pllLocked = 1'b1;
    for (int edgeCount = 1; edgeCount <= or1420CiPkg::RESET_CYCLES; edgeCount++) begin
      @(posedge s_systemClock);
      #1;
      checkReset(systemReset, edgeCount < or1420CiPkg::RESET_CYCLES,
                 $sformatf("%0d edges after lock", edgeCount));
      checkDone(ciDone, 1'b0, "idle bus while leaving reset");
    end

    foreach (stepTable[stepIndex]) begin
      step = stepTable[stepIndex];
      runCycle(1'b1, step.number, step.dataA, step.dataB, 1'b0, 1'b0);
      for (int idleIndex = 0; idleIndex < step.idleCycles; idleIndex++) begin
        randomWord = $random(seed);
        runCycle(1'b0, step.number, step.dataA, step.dataB, randomWord[0], randomWord[1]);
      end
    end
    checkReset(systemReset, 1'b0, "end of the run");

    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // the limit is twice the length of the reset and of every table entry.
  initial begin
    int limitNs;
    wait (tableLoaded === 1'b1);
    limitNs = (LOCK_DELAY_CYCLES + or1420CiPkg::RESET_CYCLES + 1) * CLOCK_PERIOD;
    foreach (stepTable[index]) begin
      limitNs += (1 + stepTable[index].idleCycles) * CLOCK_PERIOD;
    end
    limitNs = 2 * limitNs;
    #(limitNs);
    $display("The run timed out: the tests did not finish within %0d ns.", limitNs);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* or1420CustomInstructions.sv */
`timescale 1ns/1ps

module or1420CustomInstructions (
  input  logic                  s_systemClock,
  input  logic                  s_pllLocked,
  input  logic                  ciStart,
  input  logic                  stall,
  input  logic                  busIdle,
  input  or1420CiPkg::ciNumberT ciN,
  input  or1420CiPkg::ciWordT   ciDataA,
  input  or1420CiPkg::ciWordT   ciDataB,
  output logic                  systemReset,
  output logic                  ciDone,
  output or1420CiPkg::ciWordT   ciResult
);

  logic                      dataFormatDone;
  or1420CiPkg::ciWordT       dataFormatResult;
  logic                      profileDone;
  or1420CiPkg::ciWordT       profileResult;
  logic                      profileAccess;
  or1420CiPkg::profileMaskT  profileEnable;
  or1420CiPkg::profileMaskT  profileClear;
  or1420CiPkg::profileCountT profileCount [or1420CiPkg::NR_OF_PROFILE_COUNTERS];

  resetSequencer resetGen (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .systemReset  (systemReset)
  );

  dataFormatIse dataFormat (
    .ciStart (ciStart),
    .ciN     (ciN),
    .ciDataA (ciDataA),
    .ciDone  (dataFormatDone),
    .ciResult(dataFormatResult)
  );

  profileControl profileCtrl (
    .s_systemClock(s_systemClock),
    .systemReset  (systemReset),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataB      (ciDataB),
    .stall        (stall),
    .busIdle      (busIdle),
    .profileEnable(profileEnable),
    .profileClear (profileClear),
    .profileAccess(profileAccess)
  );

  for (genvar counterIndex = 0; counterIndex < or1420CiPkg::NR_OF_PROFILE_COUNTERS;
       counterIndex++) begin : gen_profileCounters
    profileCounter counter (
      .s_systemClock(s_systemClock),
      .systemReset  (systemReset),
      .counterEnable(profileEnable[counterIndex]),
      .counterClear (profileClear[counterIndex]),
      .profileCount (profileCount[counterIndex])
    );
  end

  profileReadout profileRead (
    .profileAccess(profileAccess),
    .ciDataA      (ciDataA),
    .profileCount (profileCount),
    .ciDone       (profileDone),
    .ciResult     (profileResult)
  );

  // units that are not addressed drive zero, so the answers can simply be or-ed.
  assign ciDone   = dataFormatDone | profileDone;
  assign ciResult = dataFormatResult | profileResult;

endmodule

/* profileReadout.sv */
`timescale 1ns/1ps

module profileReadout (
  input  logic                      profileAccess,
  input  or1420CiPkg::ciWordT       ciDataA,
  input  or1420CiPkg::profileCountT profileCount [or1420CiPkg::NR_OF_PROFILE_COUNTERS],
  output logic                      ciDone,
  output or1420CiPkg::ciWordT       ciResult
);

  or1420CiPkg::profileSelectT counterSelect;

  assign counterSelect = ciDataA[$bits(or1420CiPkg::profileSelectT)-1:0];
  assign ciDone = profileAccess;

  always_comb begin
    ciResult = '0;
    if (profileAccess) begin
      ciResult = profileCount[counterSelect]; // value before this command's edge.
    end
    idleResultZero : assert (ciDone || (ciResult == '0))
      else $error("profile result is not zero while done is low.");
  end

endmodule

/* profileCounter.sv */
`timescale 1ns/1ps

module profileCounter (
  input  logic                      s_systemClock,
  input  logic                      systemReset,
  input  logic                      counterEnable,
  input  logic                      counterClear,
  output or1420CiPkg::profileCountT profileCount
);

  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      profileCount <= '0;
    end else if (counterClear) begin
      profileCount <= '0; // a clear in the same cycle drops the event.
    end else if (counterEnable) begin
      profileCount <= profileCount + or1420CiPkg::profileCountT'(1); // wraps around.
    end
  end

endmodule

/* profileControl.sv */
`timescale 1ns/1ps

module profileControl (
  input  logic                     s_systemClock,
  input  logic                     systemReset,
  input  logic                     ciStart,
  input  or1420CiPkg::ciNumberT    ciN,
  input  or1420CiPkg::ciWordT      ciDataB,
  input  logic                     stall,
  input  logic                     busIdle,
  output or1420CiPkg::profileMaskT profileEnable,
  output or1420CiPkg::profileMaskT profileClear,
  output logic                     profileAccess
);

  or1420CiPkg::profileMaskT runMask;
  or1420CiPkg::profileMaskT startMask;
  or1420CiPkg::profileMaskT stopMask;
  or1420CiPkg::profileMaskT clearMask;
  or1420CiPkg::profileMaskT counterEvents;

  assign profileAccess = ciStart && (ciN == or1420CiPkg::PROFILE_ID);

  assign startMask = ciDataB[3:0];
  assign stopMask  = ciDataB[7:4];
  assign clearMask = ciDataB[11:8];

  // counter 0 counts every cycle, counter 3 the cycles that are neither stalled nor idle.
  assign counterEvents[0] = 1'b1;
  assign counterEvents[1] = stall;
  assign counterEvents[2] = busIdle;
  assign counterEvents[3] = ~stall & ~busIdle;

  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      runMask <= '0;
    end else if (profileAccess) begin
      runMask <= (runMask | startMask) & ~stopMask; // a stop wins over a start.
    end
  end

  assign profileEnable = runMask & counterEvents;
  assign profileClear  = profileAccess ? clearMask : '0;

  // Clears may only reach the counters at the edge of a profile command.
  clearNeedsAccess : assert property (
    @(posedge s_systemClock) disable iff (systemReset)
    (profileClear != '0) |-> profileAccess
  ) else $error("profile counter cleared outside a profile command.");

endmodule

/* dataFormatIse.sv */
`timescale 1ns/1ps

module dataFormatIse (
  input  logic                  ciStart,
  input  or1420CiPkg::ciNumberT ciN,
  input  or1420CiPkg::ciWordT   ciDataA,
  output logic                  ciDone,
  output or1420CiPkg::ciWordT   ciResult
);

  logic                swapSelect;
  logic                graySelect;
  or1420CiPkg::ciWordT swappedWord;
  logic [7:0]          redChannel;
  logic [7:0]          greenChannel;
  logic [7:0]          blueChannel;
  logic [15:0]         weightedSum;
  logic [7:0]          grayValue;

  assign swapSelect = ciStart && (ciN == or1420CiPkg::SWAP_BYTE_ID);
  assign graySelect = ciStart && (ciN == or1420CiPkg::GRAYSCALE_ID);

  assign swappedWord = {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]};

  // the rgb565 pixel sits in the low half word.
  assign redChannel   = {ciDataA[15:11], 3'b000};
  assign greenChannel = {ciDataA[10:5], 2'b00};
  assign blueChannel  = {ciDataA[4:0], 3'b000};

  // The largest possible sum stays below 2^16 because the weights add up to 256.
  assign weightedSum = 16'(redChannel) * 16'(or1420CiPkg::RED_WEIGHT) +
                       16'(greenChannel) * 16'(or1420CiPkg::GREEN_WEIGHT) +
                       16'(blueChannel) * 16'(or1420CiPkg::BLUE_WEIGHT);
  assign grayValue = weightedSum[15:8]; // divide by the weight total.

  assign ciDone = swapSelect | graySelect;

  always_comb begin
    ciResult = '0;
    if (swapSelect) begin
      ciResult = swappedWord;
    end else if (graySelect) begin
      ciResult = {24'd0, grayValue};
    end
  end

endmodule

/* resetSequencer.sv */
`timescale 1ns/1ps

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic systemReset
);

  or1420CiPkg::resetCountT resetCount;
  logic                    countDone;

  assign countDone = resetCount[$bits(or1420CiPkg::resetCountT)-1];
  assign systemReset = ~countDone; // released once the top bit is reached.

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!countDone) begin
      resetCount <= resetCount + or1420CiPkg::resetCountT'(1);
    end
  end

  // Once released, the system stays out of reset for as long as the PLL keeps its lock.
  releaseHolds : assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    !systemReset |=> !systemReset
  ) else $error("systemReset rose again while the PLL stayed locked.");

endmodule

/* or1420CiPkg.sv */
package or1420CiPkg;

  // custom instruction interface widths.
  typedef logic [7:0]  ciNumberT;
  typedef logic [31:0] ciWordT;

  localparam int NR_OF_PROFILE_COUNTERS = 4;
  localparam int RESET_CYCLES = 16;

  // one bit per profile counter.
  typedef logic [NR_OF_PROFILE_COUNTERS-1:0]         profileMaskT;
  typedef logic [$clog2(NR_OF_PROFILE_COUNTERS)-1:0] profileSelectT;
  typedef logic [31:0]                               profileCountT;

  // the top bit of the reset counter is set exactly RESET_CYCLES clocks after lock.
  typedef logic [$clog2(RESET_CYCLES):0] resetCountT;

  // instruction numbers as the processor issues them.
  localparam ciNumberT SWAP_BYTE_ID = 8'd1;
  localparam ciNumberT GRAYSCALE_ID = 8'd10;
  localparam ciNumberT PROFILE_ID   = 8'd12;

  // the luminance weights add up to 256.
  localparam logic [7:0] RED_WEIGHT   = 8'd54;
  localparam logic [7:0] GREEN_WEIGHT = 8'd183;
  localparam logic [7:0] BLUE_WEIGHT  = 8'd19;

endpackage
